/* accum/kulischAccumTop.sv */
//--------------------------------------------------------------------------
// Streaming Kulisch accumulator top
// Alignment stage followed by the summing stage, two cycles input to result
//--------------------------------------------------------------------------
module kulischAccumTop import kulischPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  logic    inClear,
  input  expT     inExp,
  input  productT inFixed,
  input  logic    inInf,
  output logic    outValid,
  output accWordT sumBits,
  output logic    sumInf,
  output logic    sumOverflow,
  output logic    sumOverflowSign
);

  // Stage 1 to stage 2
  logic    convValid;
  logic    convClear;
  accWordT alignedBits;
  logic    alignedInf;
  logic    alignedOverflow;
  logic    alignedOverflowSign;

  // Alignment, truncation and overflow detection
  kulischConvertFixed convert_i (
    .clk                 (clk),
    .rst                 (rst),
    .inValid             (inValid),
    .inClear             (inClear),
    .inExp               (inExp),
    .inFixed             (inFixed),
    .inInf               (inInf),
    .convValid           (convValid),
    .convClear           (convClear),
    .alignedBits         (alignedBits),
    .alignedInf          (alignedInf),
    .alignedOverflow     (alignedOverflow),
    .alignedOverflowSign (alignedOverflowSign)
  );

  // Exact running sum
  kulischAccumulate accumulate_i (
    .clk                 (clk),
    .rst                 (rst),
    .convValid           (convValid),
    .convClear           (convClear),
    .alignedBits         (alignedBits),
    .alignedInf          (alignedInf),
    .alignedOverflow     (alignedOverflow),
    .alignedOverflowSign (alignedOverflowSign),
    .outValid            (outValid),
    .sumBits             (sumBits),
    .sumInf              (sumInf),
    .sumOverflow         (sumOverflow),
    .sumOverflowSign     (sumOverflowSign)
  );

endmodule

/* accum/kulischAccumulate.sv */
//--------------------------------------------------------------------------
// Stage 2: running exact sum with sticky inf and overflow flags
// Clear strobe loads the addend in place of adding it
//--------------------------------------------------------------------------
`include "kulisch_macros.svh"

module kulischAccumulate import kulischPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    convValid,
  input  logic    convClear,
  input  accWordT alignedBits,
  input  logic    alignedInf,
  input  logic    alignedOverflow,
  input  logic    alignedOverflowSign,
  output logic    outValid,
  output accWordT sumBits,
  output logic    sumInf,
  output logic    sumOverflow,
  output logic    sumOverflowSign
);

  localparam int signPos = `KULISCH_ACC_BITS - 1;

  // Wrapping two's complement sum
  accWordT addResult;
  // Operand and result signs
  logic    sumSign;
  logic    addendSign;
  logic    resultSign;
  // Same-sign operands giving a result of the other sign
  logic    addOverflow;
  // Next overflow sign when the flag is still clear
  logic    firstOverflowSign;

  always_comb begin
    addResult  = sumBits + alignedBits;
    sumSign    = sumBits[signPos];
    addendSign = alignedBits[signPos];
    resultSign = addResult[signPos];

    addOverflow = (sumSign == addendSign) && (resultSign != sumSign);

    // Addend overflow wins when both happen on the same item
    if (alignedOverflow) begin
      firstOverflowSign = alignedOverflowSign;
    end else begin
      firstOverflowSign = sumSign;
    end
  end

  // Result strobe one cycle behind the aligned item
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else begin
      outValid <= convValid;
    end
  end

  // Sum and sticky flags
  always_ff @(posedge clk) begin
    if (rst) begin
      sumBits         <= '0;
      sumInf          <= 1'b0;
      sumOverflow     <= 1'b0;
      sumOverflowSign <= 1'b0;
    end else if (convValid) begin
      if (convClear) begin
        // New sum from this item alone
        sumBits         <= alignedBits;
        sumInf          <= alignedInf;
        sumOverflow     <= alignedOverflow;
        sumOverflowSign <= alignedOverflowSign;
      end else begin
        sumBits <= addResult;
        sumInf  <= sumInf | alignedInf;
        // Sign is latched at the first overflow only
        if (!sumOverflow && (alignedOverflow || addOverflow)) begin
          sumOverflow     <= 1'b1;
          sumOverflowSign <= firstOverflowSign;
        end
      end
    end
  end

endmodule

/* accum/kulischConvertFixed.sv */
//--------------------------------------------------------------------------
// Stage 1: aligns a fixed-point product to the accumulator word
// Truncates the low fraction bits and flags overflow, then registers it
//--------------------------------------------------------------------------
`include "kulisch_macros.svh"

module kulischConvertFixed import kulischPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  logic    inClear,
  input  expT     inExp,
  input  productT inFixed,
  input  logic    inInf,
  output logic    convValid,
  output logic    convClear,
  output accWordT alignedBits,
  output logic    alignedInf,
  output logic    alignedOverflow,
  output logic    alignedOverflowSign
);

  localparam int prodBits = $bits(productT);
  localparam int extBits  = `KULISCH_EXT_BITS;
  localparam int accBits  = `KULISCH_ACC_BITS;

  // Product sign
  logic                 fixedSign;
  // Product sign-extended to the shifter width
  //   sssssssssssssssssssssss smm.ffffffff
  logic [extBits-1:0]   fixedExtended;
  // After the exponent shift
  logic [extBits-1:0]   fixedShifted;
  // OR of the lost top bits, overflow test for positive values
  logic                 stickyOr;
  // AND of the lost top bits, overflow test for negative values
  logic                 stickyAnd;
  // Top accumulator-width bits of the shifted value
  accWordT              fixedTruncated;
  logic                 overflow;

  assign fixedSign     = inFixed[prodBits-1];
  assign fixedExtended = {{(extBits-prodBits){fixedSign}}, inFixed};

  shiftLeftSticky alignShift_i (
    .in        (fixedExtended),
    .shift     (inExp),
    .out       (fixedShifted),
    .stickyOr  (stickyOr),
    .stickyAnd (stickyAnd)
  );

  // Low KULISCH_FRAC bits fall below the accumulator LSB and are dropped
  assign fixedTruncated = fixedShifted[extBits-1 -: accBits];

  // Overflow when a bit unlike the sign left the top
  // or when the kept sign bit no longer matches the product sign
  always_comb begin
    if (fixedSign) begin
      overflow = !stickyAnd || !fixedTruncated[accBits-1];
    end else begin
      overflow = stickyOr || fixedTruncated[accBits-1];
    end
  end

  // Strobes follow the input by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      convValid <= 1'b0;
      convClear <= 1'b0;
    end else begin
      convValid <= inValid;
      convClear <= inClear;
    end
  end

  // Aligned word and flags, captured with each accepted product
  always_ff @(posedge clk) begin
    if (inValid) begin
      alignedBits         <= fixedTruncated;
      alignedInf          <= inInf;
      alignedOverflow     <= overflow;
      alignedOverflowSign <= overflow && fixedSign;
    end
  end

endmodule

/* bench/kulischAccumTb.sv */
//--------------------------------------------------------------------------
// Testbench for the Kulisch accumulator top
// Clock, reset, LFSR stimulus, test sequence and per-test reporting
//--------------------------------------------------------------------------
module kulischAccumTb import kulischPkg::*; ();

  localparam int driveDelay = 2;
  localparam int waitLimit  = 50;

  logic    clk;
  logic    rst;
  logic    inValid;
  logic    inClear;
  expT     inExp;
  productT inFixed;
  logic    inInf;
  logic    outValid;
  accWordT sumBits;
  logic    sumInf;
  logic    sumOverflow;
  logic    sumOverflowSign;

  logic [31:0] lfsrState;
  int          testNum;
  int          testsFailed;
  int          timeoutCount;
  // Counter snapshots at the start of a test
  int          startFails;
  int          startTimeouts;

  kulischAccumTop dut_i (
    .clk             (clk),
    .rst             (rst),
    .inValid         (inValid),
    .inClear         (inClear),
    .inExp           (inExp),
    .inFixed         (inFixed),
    .inInf           (inInf),
    .outValid        (outValid),
    .sumBits         (sumBits),
    .sumInf          (sumInf),
    .sumOverflow     (sumOverflow),
    .sumOverflowSign (sumOverflowSign)
  );

  always #20 clk = ~clk;

  // One Galois step with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  // Collects count bits with one LFSR step per bit
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return value;
  endfunction

  task automatic sendItem(input logic clear, input expT itemExp, input productT fixed,
                          input logic inf);
    @(posedge clk);
    #driveDelay;
    inValid = 1'b1;
    inClear = clear;
    inExp   = itemExp;
    inFixed = fixed;
    inInf   = inf;
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #driveDelay;
    inValid = 1'b0;
    inClear = 1'b0;
    inInf   = 1'b0;
  endtask

  // Waits for a result strobe at each falling edge
  task automatic waitForOutput(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!outValid && cycles < waitLimit);
    if (!outValid) begin
      timeoutCount++;
      $display("Timeout: no result appeared during %s within %0d cycles", what, waitLimit);
    end
  endtask

  // Three low cycles in a row mean the two-stage pipeline is empty
  task automatic waitQuiet(input string what);
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    while (quiet < 3 && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
      quiet = outValid ? 0 : quiet + 1;
    end
    if (quiet < 3) begin
      timeoutCount++;
      $display("Timeout: results kept coming during %s after %0d cycles", what, waitLimit);
    end
  endtask

  task automatic finishBurst(input string what);
    idleCycle();
    waitForOutput(what);
    waitQuiet(what);
  endtask

  task automatic beginTest();
    startFails    = dut_i.checker_i.failCount;
    startTimeouts = timeoutCount;
  endtask

  task automatic endTest(input string name);
    int fails;
    fails = (dut_i.checker_i.failCount - startFails) + (timeoutCount - startTimeouts);
    if (fails == 0) begin
      $display("Test %0d %s: ok", testNum, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: %0d failures", testNum, name, fails);
    end
    testNum++;
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    inValid      = 1'b0;
    inClear      = 1'b0;
    inExp        = '0;
    inFixed      = '0;
    inInf        = 1'b0;
    lfsrState    = 32'h134a2b0c;
    testNum      = 1;
    testsFailed  = 0;
    timeoutCount = 0;

    repeat (4) @(posedge clk);
    #driveDelay;
    rst = 1'b0;

    beginTest();
    repeat (8) idleCycle();
    endTest("idle after reset");

    // Exponents up to 15 keep both the items and the sum in range
    beginTest();
    sendItem(1'b1, expT'(takeBits(4)), productT'(takeBits(11)), 1'b0);
    repeat (24) sendItem(1'b0, expT'(takeBits(4)), productT'(takeBits(11)), 1'b0);
    finishBurst("random products");
    endTest("random in-range products");

    // Positive overflow first and a later negative one must not move the sign
    beginTest();
    sendItem(1'b1, 6'd8, productT'(11'd100), 1'b0);
    sendItem(1'b0, 6'd40, productT'({2'b01, 9'(takeBits(9))}), 1'b0);
    sendItem(1'b0, 6'd5, productT'(takeBits(11)), 1'b0);
    sendItem(1'b0, expT'(24 + takeBits(5)), productT'({2'b10, 9'(takeBits(9))}), 1'b0);
    sendItem(1'b0, 6'd3, productT'(takeBits(11)), 1'b0);
    finishBurst("positive item overflow");
    // Negative overflow after a small clear item keeps its sign past a positive one
    sendItem(1'b1, 6'd6, productT'(takeBits(11)), 1'b0);
    sendItem(1'b0, expT'(24 + takeBits(5)), productT'({2'b10, 9'(takeBits(9))}), 1'b0);
    sendItem(1'b0, 6'd7, productT'(takeBits(11)), 1'b0);
    sendItem(1'b0, 6'd63, productT'({2'b01, 9'(takeBits(9))}), 1'b0);
    finishBurst("negative item overflow");
    endTest("item overflow");

    // Largest in-range positive item where two of them leave the word range
    beginTest();
    sendItem(1'b1, 6'd23, productT'(11'h3ff), 1'b0);
    repeat (3) sendItem(1'b0, 6'd23, productT'(11'h3ff), 1'b0);
    sendItem(1'b0, 6'd20, productT'({2'b10, 9'(takeBits(9))}), 1'b0);
    finishBurst("positive sum overflow");
    // Most negative item followed by another negative one
    sendItem(1'b1, 6'd23, productT'(11'h400), 1'b0);
    sendItem(1'b0, 6'd22, productT'({2'b10, 9'(takeBits(9))}), 1'b0);
    finishBurst("negative sum overflow");
    endTest("sum overflow");

    beginTest();
    sendItem(1'b1, 6'd10, productT'(takeBits(11)), 1'b0);
    sendItem(1'b0, 6'd10, productT'(takeBits(11)), 1'b1);
    repeat (4) sendItem(1'b0, expT'(takeBits(4)), productT'(takeBits(11)), 1'b0);
    // Clear drops the sticky inf
    sendItem(1'b1, 6'd10, productT'(takeBits(11)), 1'b0);
    sendItem(1'b0, 6'd9, productT'(takeBits(11)), 1'b0);
    // Clear carrying inf and overflow of its own
    sendItem(1'b1, 6'd30, productT'(11'h200), 1'b1);
    sendItem(1'b0, 6'd4, productT'(takeBits(11)), 1'b0);
    finishBurst("inf and clear");
    endTest("sticky inf and clear");

    // Dense stream with gaps, clears, inf items and some overflows
    beginTest();
    sendItem(1'b1, expT'(takeBits(4)), productT'(takeBits(11)), 1'b0);
    repeat (48) begin
      if (takeBits(3) == 0) begin
        idleCycle();
      end else begin
        sendItem(takeBits(3) == 0, expT'(takeBits(5)), productT'(takeBits(11)),
                 takeBits(4) == 0);
      end
    end
    finishBurst("mixed stream");
    endTest("back-to-back stream");

    $display("Tests run %0d, tests failed %0d, assertion failures %0d, timeouts %0d",
             testNum - 1, testsFailed, dut_i.checker_i.failCount, timeoutCount);
    if (testsFailed == 0 && dut_i.checker_i.failCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* bench/kulischAccum_asserts.sv */
//--------------------------------------------------------------------------
// Bound checker for the Kulisch accumulator top
// Shadow model of alignment and running sum, checked by concurrent assertions
//--------------------------------------------------------------------------
`include "kulisch_macros.svh"

module kulischAccum_asserts import kulischPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    inValid,
  input logic    inClear,
  input expT     inExp,
  input productT inFixed,
  input logic    inInf,
  input logic    outValid,
  input accWordT sumBits,
  input logic    sumInf,
  input logic    sumOverflow,
  input logic    sumOverflowSign
);

  localparam int prodBits = $bits(productT);
  localparam int accBits  = `KULISCH_ACC_BITS;
  localparam int fracBits = `KULISCH_FRAC;
  // Holds the largest product at the largest exponent with room to spare
  localparam int wideBits = 96;

  // Exact shifted product, in units of the product LSB
  logic signed [wideBits-1:0] wideValue;
  // Same value in accumulator LSB units, floor of the division
  logic signed [wideBits-1:0] wideFloor;
  accWordT                    alignWord;
  logic                       alignOvf;

  // Model item one cycle after the input
  logic    validDly1;
  logic    clearDly1;
  accWordT itemWord;
  logic    itemInf;
  logic    itemOvf;
  logic    itemOvfSign;

  // Model result, lined up with outValid
  logic    validDly2;
  accWordT modelSum;
  logic    modelInf;
  logic    modelOvf;
  logic    modelOvfSign;
  // Exact sum one bit wider than the word
  logic [accBits:0] wideSum;
  logic             addOvf;

  // Failure counters, summed for the testbench
  int timingFails = 0;
  int resetFails  = 0;
  int bitsFails   = 0;
  int infFails    = 0;
  int ovfFails    = 0;
  int signFails   = 0;
  int failCount;

  assign failCount = timingFails + resetFails + bitsFails + infFails + ovfFails + signFails;

  always_comb begin
    wideValue = {{(wideBits-prodBits){inFixed[prodBits-1]}}, inFixed} << inExp;
    wideFloor = wideValue >>> fracBits;
    alignWord = wideFloor[accBits-1:0];
    // Fits only if the kept word sign-extends back to the exact value
    alignOvf  = wideFloor != {{(wideBits-accBits){alignWord[accBits-1]}}, alignWord};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      validDly1   <= 1'b0;
      clearDly1   <= 1'b0;
      itemWord    <= '0;
      itemInf     <= 1'b0;
      itemOvf     <= 1'b0;
      itemOvfSign <= 1'b0;
    end else begin
      validDly1 <= inValid;
      clearDly1 <= inClear;
      if (inValid) begin
        itemWord    <= alignWord;
        itemInf     <= inInf;
        itemOvf     <= alignOvf;
        itemOvfSign <= alignOvf && inFixed[prodBits-1];
      end
    end
  end

  always_comb begin
    wideSum = {modelSum[accBits-1], modelSum} + {itemWord[accBits-1], itemWord};
    // Top two bits disagree when the exact sum leaves the word range
    addOvf  = wideSum[accBits] != wideSum[accBits-1];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      validDly2    <= 1'b0;
      modelSum     <= '0;
      modelInf     <= 1'b0;
      modelOvf     <= 1'b0;
      modelOvfSign <= 1'b0;
    end else begin
      validDly2 <= validDly1;
      if (validDly1 && clearDly1) begin
        modelSum     <= itemWord;
        modelInf     <= itemInf;
        modelOvf     <= itemOvf;
        modelOvfSign <= itemOvfSign;
      end else if (validDly1) begin
        modelSum <= wideSum[accBits-1:0];
        modelInf <= modelInf | itemInf;
        // First overflow fixes the sign, addend overflow taking priority
        if (!modelOvf && (itemOvf || addOvf)) begin
          modelOvf     <= 1'b1;
          modelOvfSign <= itemOvf ? itemOvfSign : wideSum[accBits];
        end
      end
    end
  end

  outValidTiming: assert property (@(posedge clk) disable iff (rst) outValid == validDly2)
    else begin
      timingFails++;
      $error("[ERROR] t=%0t outValid got %b expected %b", $time,
             $sampled(outValid), $sampled(validDly2));
    end

  // Idle and zero right after reset
  resetState: assert property (@(posedge clk) rst |=> (!outValid && sumBits == '0))
    else begin
      resetFails++;
      $error("[ERROR] t=%0t outValid/sumBits got %b/%h expected 0/0", $time,
             $sampled(outValid), $sampled(sumBits));
    end

  sumBitsMatch: assert property (@(posedge clk) disable iff (rst)
      outValid |-> sumBits == modelSum)
    else begin
      bitsFails++;
      $error("[ERROR] t=%0t sumBits got %h expected %h", $time,
             $sampled(sumBits), $sampled(modelSum));
    end

  sumInfMatch: assert property (@(posedge clk) disable iff (rst)
      outValid |-> sumInf == modelInf)
    else begin
      infFails++;
      $error("[ERROR] t=%0t sumInf got %b expected %b", $time,
             $sampled(sumInf), $sampled(modelInf));
    end

  sumOverflowMatch: assert property (@(posedge clk) disable iff (rst)
      outValid |-> sumOverflow == modelOvf)
    else begin
      ovfFails++;
      $error("[ERROR] t=%0t sumOverflow got %b expected %b", $time,
             $sampled(sumOverflow), $sampled(modelOvf));
    end

  sumOverflowSignMatch: assert property (@(posedge clk) disable iff (rst)
      outValid |-> sumOverflowSign == modelOvfSign)
    else begin
      signFails++;
      $error("[ERROR] t=%0t sumOverflowSign got %b expected %b", $time,
             $sampled(sumOverflowSign), $sampled(modelOvfSign));
    end

endmodule

bind kulischAccumTop kulischAccum_asserts checker_i (
  .clk             (clk),
  .rst             (rst),
  .inValid         (inValid),
  .inClear         (inClear),
  .inExp           (inExp),
  .inFixed         (inFixed),
  .inInf           (inInf),
  .outValid        (outValid),
  .sumBits         (sumBits),
  .sumInf          (sumInf),
  .sumOverflow     (sumOverflow),
  .sumOverflowSign (sumOverflowSign)
);

/* common/kulischPkg.sv */
//--------------------------------------------------------------------------
// Types shared by the accumulator stages and the checker
//--------------------------------------------------------------------------
`include "kulisch_macros.svh"

package kulischPkg;

  // Accumulator word
  // Two's complement with sign, integer and fraction fields
  //   s iiiiiiiiiiiii ffffffffffff
  typedef logic signed [`KULISCH_ACC_BITS-1:0] accWordT;

  // Product from the multiplier
  // Two's complement smm.ffff with two integer bits below the sign
  typedef logic signed [3+`KULISCH_FRAC-1:0] productT;

  // Product exponent
  // Zero puts the product LSB KULISCH_FRAC places below the accumulator LSB
  typedef logic [`KULISCH_EXP-1:0] expT;

endpackage

/* common/kulisch_macros.svh */
//--------------------------------------------------------------------------
// Field widths of the product and of the Kulisch accumulator
//--------------------------------------------------------------------------
`ifndef KULISCH_MACROS_SVH
`define KULISCH_MACROS_SVH

// Fraction bits of an incoming product smm.ffff
`define KULISCH_FRAC 8

// Exponent width, also the shift amount width
`define KULISCH_EXP 6

// Integer bits of the accumulator without the sign
`define KULISCH_ACC_NON_FRAC 13

// Fraction bits of the accumulator
`define KULISCH_ACC_FRAC 12

// Sign plus integer plus fraction bits of the accumulator
`define KULISCH_ACC_BITS (1 + `KULISCH_ACC_NON_FRAC + `KULISCH_ACC_FRAC)

// Shifter working width
// Product fraction bits hang below the accumulator LSB before truncation
`define KULISCH_EXT_BITS (`KULISCH_ACC_BITS + `KULISCH_FRAC)

`endif

/* logic/shiftLeftSticky.sv */
//--------------------------------------------------------------------------
// Variable left shifter with OR and AND of the bits pushed out the top
//--------------------------------------------------------------------------
`include "kulisch_macros.svh"

module shiftLeftSticky import kulischPkg::*; (
  input  logic [`KULISCH_EXT_BITS-1:0] in,
  input  expT                          shift,
  output logic [`KULISCH_EXT_BITS-1:0] out,
  output logic                         stickyOr,
  output logic                         stickyAnd
);

  localparam int extWidth = `KULISCH_EXT_BITS;

  // Upper half of the double-width result catches the bits pushed out
  logic [2*extWidth-1:0] wideShifted;
  // Ones in the upper half mark positions actually reached by the shift
  logic [2*extWidth-1:0] wideMask;
  logic [extWidth-1:0]   lostBits;
  logic [extWidth-1:0]   lostMask;
  // Shift count at or past the width
  logic                  fullShift;

  always_comb begin
    fullShift   = (shift >= expT'(extWidth));
    wideShifted = {{extWidth{1'b0}}, in} << shift;
    wideMask    = {{extWidth{1'b0}}, {extWidth{1'b1}}} << shift;
    lostBits    = wideShifted[2*extWidth-1:extWidth];
    lostMask    = wideMask[2*extWidth-1:extWidth];

    if (fullShift) begin
      // Every input bit leaves the word
      out       = '0;
      stickyOr  = |in;
      stickyAnd = &in;
    end else begin
      out      = wideShifted[extWidth-1:0];
      // Zero padding above the lost bits keeps the OR exact
      stickyOr = |lostBits;
      // Unreached positions count as ones so the AND sees only lost bits
      // An empty set of lost bits gives one
      stickyAnd = &(lostBits | ~lostMask);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Builds the Kulisch accumulator testbench with Verilator and runs it
# Pass or fail comes from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module kulischAccumTb -f verilog.f \
  -o kulischAccumSim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

# Keep running after assertion errors so the testbench prints its verdict
./obj_dir/kulischAccumSim +verilator+error+limit+1000 > sim.log 2>&1

grep -q "Simulation PASSED" sim.log \
  && { echo "Run passed"; exit 0; } \
  || { echo "Run failed, see sim.log"; exit 1; }

/* verilog.f */
+incdir+common
common/kulischPkg.sv
logic/shiftLeftSticky.sv
accum/kulischConvertFixed.sv
accum/kulischAccumulate.sv
accum/kulischAccumTop.sv
bench/kulischAccum_asserts.sv
bench/kulischAccumTb.sv
